// File: sources.f
hdl/ptr_alloc_pkg.sv
hdl/bitmap_ram.sv
hdl/id_fifo.sv
hdl/free_scan.sv
hdl/alloc_ctrl.sv
hdl/active_counter.sv
hdl/ptr_allocator.sv
sim/ptr_allocator_assertions.sv
sim/ptr_allocator_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ptr_allocator_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+100
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from grep, so a missing pass line fails the target
run: compile
	$(SIM_BIN) $(SIM_ARGS) | tee /dev/stderr | grep -xF '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: sim/ptr_allocator_tb.sv
// Pointer allocator testbench
// Allocation and free traffic checked against a free-bitmap model
module ptr_allocator_tb;

    localparam int clk_period      = 100;
    localparam int drive_delay     = 10;
    localparam int wait_limit      = 400;
    localparam int watchdog_cycles = ptr_alloc_pkg::num_ids * 3 * 40 + 200;

    logic                            clk;
    logic                            local_srst;
    logic                            en;
    logic                            alloc_req;
    logic                            dealloc_req;
    ptr_alloc_pkg::ptr_id_t          dealloc_id;
    logic                            init_done;
    logic                            alloc_rdy;
    ptr_alloc_pkg::ptr_id_t          alloc_id;
    logic                            dealloc_rdy;
    logic                            err_alloc;
    logic                            err_dealloc;
    ptr_alloc_pkg::ptr_id_t          err_id;
    logic [ptr_alloc_pkg::cnt_w-1:0] active_count;

    // Model of the pool, a set flag means the ID is free
    logic   model_free [ptr_alloc_pkg::num_ids];
    int     pending_q [$];
    int     prev_count;
    int     checks;
    int     errors;
    integer seed;
    string  test_name;

    ptr_allocator i_dut (
        .clk          (clk),
        .local_srst   (local_srst),
        .en           (en),
        .alloc_req    (alloc_req),
        .dealloc_req  (dealloc_req),
        .dealloc_id   (dealloc_id),
        .init_done    (init_done),
        .alloc_rdy    (alloc_rdy),
        .alloc_id     (alloc_id),
        .dealloc_rdy  (dealloc_rdy),
        .err_alloc    (err_alloc),
        .err_dealloc  (err_dealloc),
        .err_id       (err_id),
        .active_count (active_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles in %s", watchdog_cycles, test_name);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display(">>> FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic int from_ptr(input ptr_alloc_pkg::ptr_id_t p);
        return int'(p.row) * ptr_alloc_pkg::num_cols + int'(p.col);
    endfunction

    function automatic ptr_alloc_pkg::ptr_id_t to_ptr(input int id);
        ptr_alloc_pkg::ptr_id_t p;
        p.row = ptr_alloc_pkg::row_idx_t'(id / ptr_alloc_pkg::num_cols);
        p.col = ptr_alloc_pkg::col_idx_t'(id % ptr_alloc_pkg::num_cols);
        return p;
    endfunction

    // Lowest free ID, the order in which a fresh pool hands out
    function automatic int expected_alloc_id();
        int id;
        int i;
        id = -1;
        for (i = ptr_alloc_pkg::num_ids - 1; i >= 0; i--) begin
            if (model_free[i]) begin
                id = i;
            end
        end
        return id;
    endfunction

    function automatic int expected_count();
        int n;
        int i;
        n = 0;
        for (i = 0; i < ptr_alloc_pkg::num_ids; i++) begin
            if (!model_free[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic report_mismatch(input int expected, input int actual);
        errors++;
        $display("Mismatch in %s: expected %0d, actual %0d", test_name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error in %s: %s", test_name, what);
    endtask

    // --------------------------------------------------
    // Comparing process, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin : compare
        int expected;
        int actual;
        if (!local_srst && init_done) begin
            if (err_dealloc) begin
                checks++;
                assert (pending_q.size() != 0) else begin
                    report_failure("err_dealloc pulsed with no free outstanding");
                end
                if (pending_q.size() != 0) begin
                    expected = pending_q.pop_front();
                    actual   = from_ptr(err_id);
                    assert (actual == expected) else report_mismatch(expected, actual);
                    assert (model_free[expected]) else begin
                        report_failure("err_dealloc on an ID that was allocated");
                    end
                end
            end else if (pending_q.size() != 0 && int'(active_count) == prev_count - 1) begin
                // Oldest outstanding free has completed
                expected = pending_q.pop_front();
                checks++;
                assert (!model_free[expected]) else begin
                    report_failure("free of an already free ID completed without error");
                end
                model_free[expected] = 1'b1;
            end else if (pending_q.size() == 0) begin
                checks++;
                assert (int'(active_count) == expected_count()) else begin
                    report_mismatch(expected_count(), int'(active_count));
                end
            end
            if (alloc_req && alloc_rdy) begin
                actual = from_ptr(alloc_id);
                checks++;
                if (test_name == "ascending") begin
                    expected = expected_alloc_id();
                    assert (actual == expected) else report_mismatch(expected, actual);
                end else begin
                    assert (model_free[actual]) else begin
                        report_failure($sformatf("ID %0d handed out twice", actual));
                    end
                end
                model_free[actual] = 1'b0;
            end
            if (dealloc_req && dealloc_rdy) begin
                pending_q.push_back(from_ptr(dealloc_id));
            end
        end
        prev_count = int'(active_count);
    end

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic step();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic random_gap();
        repeat ($unsigned($random(seed)) % 4) step();
    endtask

    task automatic take_id();
        int waited;
        waited = 0;
        while (!alloc_rdy && waited < wait_limit) begin
            step();
            waited++;
        end
        checks++;
        assert (alloc_rdy) else report_failure("alloc_rdy never rose");
        if (alloc_rdy) begin
            alloc_req = 1'b1;
            step();
            alloc_req = 1'b0;
        end
    endtask

    task automatic free_id(input int id);
        int waited;
        waited = 0;
        while (!dealloc_rdy && waited < wait_limit) begin
            step();
            waited++;
        end
        checks++;
        assert (dealloc_rdy) else report_failure("dealloc_rdy never rose");
        if (dealloc_rdy) begin
            dealloc_id  = to_ptr(id);
            dealloc_req = 1'b1;
            step();
            dealloc_req = 1'b0;
        end
    endtask

    // Frees distinct IDs that the user currently holds
    task automatic free_random_set(input int k);
        logic picked [ptr_alloc_pkg::num_ids];
        int   id;
        int   n;
        for (id = 0; id < ptr_alloc_pkg::num_ids; id++) begin
            picked[id] = 1'b0;
        end
        n = 0;
        while (n < k) begin
            id = int'($unsigned($random(seed)) % ptr_alloc_pkg::num_ids);
            if (!picked[id] && !model_free[id]) begin
                picked[id] = 1'b1;
                random_gap();
                free_id(id);
                n++;
            end
        end
    endtask

    task automatic wait_frees();
        int waited;
        waited = 0;
        while (pending_q.size() != 0 && waited < wait_limit) begin
            step();
            waited++;
        end
        checks++;
        assert (pending_q.size() == 0) else report_failure("outstanding frees never completed");
    endtask

    task automatic expect_no_alloc(input int cycles);
        repeat (cycles) begin
            step();
            checks++;
            assert (!alloc_rdy) else report_failure("alloc_rdy high with the pool exhausted");
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : stimulus
        int cycles;
        int dup_id;
        seed        = 32'h2c35dbe5;
        checks      = 0;
        errors      = 0;
        prev_count  = 0;
        local_srst  = 1'b1;
        en          = 1'b1;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_id  = '0;
        for (int i = 0; i < ptr_alloc_pkg::num_ids; i++) begin
            model_free[i] = 1'b1;
        end

        test_name = "reset";
        repeat (3) @(posedge clk);
        #(drive_delay);
        checks++;
        assert (!alloc_rdy && !dealloc_rdy && !err_alloc && !err_dealloc && !init_done
                && active_count == '0) else report_failure("outputs active during reset");
        local_srst = 1'b0;
        cycles = 0;
        while (!init_done && cycles < ptr_alloc_pkg::num_rows + 2) begin
            step();
            cycles++;
        end
        checks++;
        assert (init_done) else report_failure("init_done did not rise after the fill");

        test_name = "ascending";
        repeat (ptr_alloc_pkg::num_ids) begin
            random_gap();
            take_id();
        end
        expect_no_alloc(100);

        test_name = "refill";
        free_random_set(12);
        wait_frees();
        repeat (12) begin
            random_gap();
            take_id();
        end
        expect_no_alloc(100);

        // Second free queues behind the first, so the bit is still set
        test_name = "double_free";
        dup_id = int'($unsigned($random(seed)) % ptr_alloc_pkg::num_ids);
        free_id(dup_id);
        free_id(dup_id);
        wait_frees();
        take_id();
        expect_no_alloc(100);

        test_name = "enable";
        free_random_set(4);
        wait_frees();
        en          = 1'b0;
        alloc_req   = 1'b1;
        dealloc_req = 1'b1;
        dealloc_id  = to_ptr(0);
        repeat (20) begin
            step();
            checks++;
            assert (!alloc_rdy && !dealloc_rdy) else report_failure("ready high with en low");
        end
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        en          = 1'b1;
        repeat (4) begin
            random_gap();
            take_id();
        end
        expect_no_alloc(100);

        errors += i_dut.i_assertions.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sim/ptr_allocator_assertions.sv
// Pointer allocator protocol checks
// Bound into the top level, counts every failed property
module ptr_allocator_assertions (
    input logic                            clk,
    input logic                            local_srst,
    input logic                            init_done,
    input logic                            alloc_rdy,
    input logic                            dealloc_rdy,
    input logic                            err_alloc,
    input logic                            err_dealloc,
    input logic [ptr_alloc_pkg::cnt_w-1:0] active_count
);

    int bitmap_fails = 0;
    int ready_fails  = 0;
    int reset_fails  = 0;
    int range_fails  = 0;
    int fail_count;

    assign fail_count = bitmap_fails + ready_fails + reset_fails + range_fails;

    // Claims only ever target free bits
    no_err_alloc: assert property (@(posedge clk) disable iff (local_srst) !err_alloc)
        else begin
            bitmap_fails++;
            $error("err_alloc fired, bitmap and scanner disagree");
        end

    rdy_after_init: assert property (@(posedge clk) disable iff (local_srst)
        alloc_rdy |-> init_done)
        else begin
            ready_fails++;
            $error("alloc_rdy high before init_done");
        end

    // Synchronous reset, so outputs settle one edge after it is sampled
    quiet_in_reset: assert property (@(posedge clk) $past(local_srst) |->
        (!alloc_rdy && !dealloc_rdy && !err_alloc && !err_dealloc && !init_done
         && active_count == '0))
        else begin
            reset_fails++;
            $error("outputs active during reset");
        end

    count_in_range: assert property (@(posedge clk) disable iff (local_srst)
        int'(active_count) <= ptr_alloc_pkg::num_ids)
        else begin
            range_fails++;
            $error("active_count above pool size");
        end

endmodule

bind ptr_allocator ptr_allocator_assertions i_assertions (.*);

// File: hdl/ptr_allocator.sv
// Bitmap pointer allocator, top level
// Free bitmap, scanner and RMW controller behind alloc and dealloc queues
module ptr_allocator (
    input  logic                            clk,
    input  logic                            local_srst,
    input  logic                            en,
    input  logic                            alloc_req,
    input  logic                            dealloc_req,
    input  ptr_alloc_pkg::ptr_id_t          dealloc_id,
    output logic                            init_done,
    output logic                            alloc_rdy,
    output ptr_alloc_pkg::ptr_id_t          alloc_id,
    output logic                            dealloc_rdy,
    output logic                            err_alloc,
    output logic                            err_dealloc,
    output ptr_alloc_pkg::ptr_id_t          err_id,
    output logic [ptr_alloc_pkg::cnt_w-1:0] active_count
);

    ptr_alloc_pkg::mem_rd_t  ctrl_rd;
    ptr_alloc_pkg::mem_rd_t  scan_rd;
    ptr_alloc_pkg::mem_rd_t  mem_rd;
    ptr_alloc_pkg::mem_wr_t  mem_wr;
    ptr_alloc_pkg::mem_rsp_t mem_rsp;
    ptr_alloc_pkg::ptr_id_t  cand_id;
    ptr_alloc_pkg::ptr_id_t  dq_id;
    logic                    found;
    logic                    take;
    logic                    aq_push;
    logic                    aq_empty;
    logic                    aq_full;
    logic                    dq_pop;
    logic                    dq_empty;
    logic                    dq_full;
    logic                    freed;
    logic                    alloc_pop;
    logic                    dealloc_push;

    // --------------------------------------------------
    // User handshakes
    // --------------------------------------------------
    assign alloc_rdy    = en && !aq_empty;
    assign dealloc_rdy  = en && init_done && !dq_full;
    assign alloc_pop    = alloc_req && alloc_rdy;
    assign dealloc_push = dealloc_req && dealloc_rdy;

    // Controller reads win, scanner waits for a free cycle
    assign mem_rd = ctrl_rd.valid ? ctrl_rd : scan_rd;

    bitmap_ram i_bitmap_ram (
        .clk        (clk),
        .local_srst (local_srst),
        .rd         (mem_rd),
        .wr         (mem_wr),
        .rsp        (mem_rsp),
        .init_done  (init_done)
    );

    id_fifo i_alloc_q (
        .clk        (clk),
        .local_srst (local_srst),
        .push       (aq_push),
        .push_id    (cand_id),
        .pop        (alloc_pop),
        .head_id    (alloc_id),
        .empty      (aq_empty),
        .full       (aq_full)
    );

    id_fifo i_dealloc_q (
        .clk        (clk),
        .local_srst (local_srst),
        .push       (dealloc_push),
        .push_id    (dealloc_id),
        .pop        (dq_pop),
        .head_id    (dq_id),
        .empty      (dq_empty),
        .full       (dq_full)
    );

    free_scan i_free_scan (
        .clk        (clk),
        .local_srst (local_srst),
        .init_done  (init_done),
        .rd_grant   (!ctrl_rd.valid),
        .rsp        (mem_rsp),
        .take       (take),
        .rd         (scan_rd),
        .cand_id    (cand_id),
        .found      (found)
    );

    alloc_ctrl i_alloc_ctrl (
        .clk         (clk),
        .local_srst  (local_srst),
        .init_done   (init_done),
        .rsp         (mem_rsp),
        .found       (found),
        .cand_id     (cand_id),
        .aq_full     (aq_full),
        .dq_empty    (dq_empty),
        .dq_id       (dq_id),
        .rd          (ctrl_rd),
        .wr          (mem_wr),
        .take        (take),
        .aq_push     (aq_push),
        .dq_pop      (dq_pop),
        .freed       (freed),
        .err_alloc   (err_alloc),
        .err_dealloc (err_dealloc),
        .err_id      (err_id)
    );

    // IDs handed out count up, completed frees count down
    active_counter i_active_counter (
        .clk        (clk),
        .local_srst (local_srst),
        .inc        (alloc_pop),
        .dec        (freed),
        .count      (active_count)
    );

endmodule

// File: hdl/active_counter.sv
// Active ID counter
// Up on inc, down on dec, held when both or neither
module active_counter (
    input  logic                            clk,
    input  logic                            local_srst,
    input  logic                            inc,
    input  logic                            dec,
    output logic [ptr_alloc_pkg::cnt_w-1:0] count
);

    always_ff @(posedge clk) begin
        if (local_srst) begin
            count <= '0;
        end else if (inc && !dec) begin
            count <= count + 1'b1;
        end else if (dec && !inc) begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: hdl/alloc_ctrl.sv
// Allocation controller
// Read-modify-write of one bitmap bit per claim or free, with double-free check
module alloc_ctrl (
    input  logic                    clk,
    input  logic                    local_srst,
    input  logic                    init_done,
    input  ptr_alloc_pkg::mem_rsp_t rsp,
    input  logic                    found,
    input  ptr_alloc_pkg::ptr_id_t  cand_id,
    input  logic                    aq_full,
    input  logic                    dq_empty,
    input  ptr_alloc_pkg::ptr_id_t  dq_id,
    output ptr_alloc_pkg::mem_rd_t  rd,
    output ptr_alloc_pkg::mem_wr_t  wr,
    output logic                    take,
    output logic                    aq_push,
    output logic                    dq_pop,
    output logic                    freed,
    output logic                    err_alloc,
    output logic                    err_dealloc,
    output ptr_alloc_pkg::ptr_id_t  err_id
);

    ptr_alloc_pkg::ctrl_state_e state;
    ptr_alloc_pkg::ctrl_state_e nxt_state;
    ptr_alloc_pkg::ptr_id_t     job_id;
    ptr_alloc_pkg::row_vec_t    row_data;
    ptr_alloc_pkg::row_vec_t    wr_data;
    ptr_alloc_pkg::row_vec_t    col_mask;
    logic                       job_free;
    logic                       rsp_hit;
    logic                       bit_err;

    assign rsp_hit = rsp.valid && !rsp.scan;

    // Target bit already holds the value this job would write
    assign col_mask = ptr_alloc_pkg::row_vec_t'(1) << job_id.col;
    assign bit_err  = (row_data[job_id.col] == job_free);

    // --------------------------------------------------
    // Main FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            state <= ptr_alloc_pkg::ctrl_reset;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            ptr_alloc_pkg::ctrl_reset: begin
                if (init_done) begin
                    nxt_state = ptr_alloc_pkg::ctrl_idle;
                end
            end
            ptr_alloc_pkg::ctrl_idle: begin
                // Frees go first
                if (!dq_empty) begin
                    nxt_state = ptr_alloc_pkg::ctrl_dealloc;
                end else if (found && !aq_full) begin
                    nxt_state = ptr_alloc_pkg::ctrl_alloc;
                end
            end
            ptr_alloc_pkg::ctrl_dealloc: nxt_state = ptr_alloc_pkg::ctrl_rd_req;
            ptr_alloc_pkg::ctrl_alloc:   nxt_state = ptr_alloc_pkg::ctrl_rd_req;
            ptr_alloc_pkg::ctrl_rd_req:  nxt_state = ptr_alloc_pkg::ctrl_rd_wait;
            ptr_alloc_pkg::ctrl_rd_wait: begin
                if (rsp_hit) begin
                    nxt_state = ptr_alloc_pkg::ctrl_modify;
                end
            end
            ptr_alloc_pkg::ctrl_modify: begin
                nxt_state = bit_err ? ptr_alloc_pkg::ctrl_error : ptr_alloc_pkg::ctrl_wr;
            end
            ptr_alloc_pkg::ctrl_wr:    nxt_state = ptr_alloc_pkg::ctrl_done;
            ptr_alloc_pkg::ctrl_done:  nxt_state = ptr_alloc_pkg::ctrl_idle;
            ptr_alloc_pkg::ctrl_error: nxt_state = ptr_alloc_pkg::ctrl_idle;
            default:                   nxt_state = ptr_alloc_pkg::ctrl_reset;
        endcase
    end

    // Job capture and row update
    always_ff @(posedge clk) begin
        if (state == ptr_alloc_pkg::ctrl_dealloc) begin
            job_free <= 1'b1;
            job_id   <= dq_id;
        end else if (state == ptr_alloc_pkg::ctrl_alloc) begin
            job_free <= 1'b0;
            job_id   <= cand_id;
        end
        if (state == ptr_alloc_pkg::ctrl_rd_wait && rsp_hit) begin
            row_data <= rsp.data;
        end
        if (state == ptr_alloc_pkg::ctrl_modify) begin
            wr_data <= job_free ? (row_data | col_mask) : (row_data & ~col_mask);
        end
    end

    assign take        = (state == ptr_alloc_pkg::ctrl_alloc);
    assign aq_push     = (state == ptr_alloc_pkg::ctrl_alloc);
    assign dq_pop      = (state == ptr_alloc_pkg::ctrl_dealloc);
    assign rd.valid    = (state == ptr_alloc_pkg::ctrl_rd_req);
    assign rd.scan     = 1'b0;
    assign rd.row      = job_id.row;
    assign wr.valid    = (state == ptr_alloc_pkg::ctrl_wr);
    assign wr.row      = job_id.row;
    assign wr.data     = wr_data;
    assign freed       = (state == ptr_alloc_pkg::ctrl_done) && job_free;
    assign err_alloc   = (state == ptr_alloc_pkg::ctrl_error) && !job_free;
    assign err_dealloc = (state == ptr_alloc_pkg::ctrl_error) && job_free;
    assign err_id      = job_id;

endmodule

// File: hdl/free_scan.sv
// Free ID scanner
// Reads bitmap rows in turn and offers the lowest free column as a candidate
module free_scan (
    input  logic                    clk,
    input  logic                    local_srst,
    input  logic                    init_done,
    input  logic                    rd_grant,
    input  ptr_alloc_pkg::mem_rsp_t rsp,
    input  logic                    take,
    output ptr_alloc_pkg::mem_rd_t  rd,
    output ptr_alloc_pkg::ptr_id_t  cand_id,
    output logic                    found
);

    ptr_alloc_pkg::scan_state_e state;
    ptr_alloc_pkg::scan_state_e nxt_state;
    ptr_alloc_pkg::row_idx_t    scan_row;
    ptr_alloc_pkg::col_idx_t    scan_col;
    ptr_alloc_pkg::col_idx_t    low_col;
    ptr_alloc_pkg::row_vec_t    row_copy;
    logic                       hit;
    logic                       rsp_hit;

    assign rsp_hit = rsp.valid && rsp.scan;

    // Lowest set bit of the row copy
    always_comb begin
        hit     = 1'b0;
        low_col = '0;
        for (int i = ptr_alloc_pkg::num_cols - 1; i >= 0; i--) begin
            if (row_copy[i]) begin
                hit     = 1'b1;
                low_col = ptr_alloc_pkg::col_idx_t'(i);
            end
        end
    end

    // --------------------------------------------------
    // Scan FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            state <= ptr_alloc_pkg::scan_reset;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            ptr_alloc_pkg::scan_reset: begin
                if (init_done) begin
                    nxt_state = ptr_alloc_pkg::scan_idle;
                end
            end
            ptr_alloc_pkg::scan_idle: nxt_state = ptr_alloc_pkg::scan_rd_req;
            ptr_alloc_pkg::scan_rd_req: begin
                if (rd_grant) begin
                    nxt_state = ptr_alloc_pkg::scan_rd_wait;
                end
            end
            ptr_alloc_pkg::scan_rd_wait: begin
                if (rsp_hit) begin
                    nxt_state = ptr_alloc_pkg::scan_check;
                end
            end
            ptr_alloc_pkg::scan_check: begin
                nxt_state = hit ? ptr_alloc_pkg::scan_hold : ptr_alloc_pkg::scan_next;
            end
            ptr_alloc_pkg::scan_next: nxt_state = ptr_alloc_pkg::scan_idle;
            ptr_alloc_pkg::scan_hold: begin
                // Recheck the same row copy once the candidate is claimed
                if (take) begin
                    nxt_state = ptr_alloc_pkg::scan_check;
                end
            end
            default: nxt_state = ptr_alloc_pkg::scan_reset;
        endcase
    end

    // Row counter wraps from the last row to 0
    always_ff @(posedge clk) begin
        if (local_srst) begin
            scan_row <= '0;
        end else if (state == ptr_alloc_pkg::scan_next) begin
            scan_row <= scan_row + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ptr_alloc_pkg::scan_check) begin
            scan_col <= low_col;
        end
        if (rsp_hit) begin
            row_copy <= rsp.data;
        end else if (state == ptr_alloc_pkg::scan_hold && take) begin
            row_copy[scan_col] <= 1'b0;
        end
    end

    assign rd.valid     = (state == ptr_alloc_pkg::scan_rd_req);
    assign rd.scan      = 1'b1;
    assign rd.row       = scan_row;
    assign cand_id.row  = scan_row;
    assign cand_id.col  = scan_col;
    assign found        = (state == ptr_alloc_pkg::scan_hold);

endmodule

// File: hdl/id_fifo.sv
// Pointer ID queue
// Small first-word-fall-through FIFO, head is visible without a pop
module id_fifo (
    input  logic                   clk,
    input  logic                   local_srst,
    input  logic                   push,
    input  ptr_alloc_pkg::ptr_id_t push_id,
    input  logic                   pop,
    output ptr_alloc_pkg::ptr_id_t head_id,
    output logic                   empty,
    output logic                   full
);

    ptr_alloc_pkg::ptr_id_t              entries [ptr_alloc_pkg::fifo_depth];
    logic [ptr_alloc_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [ptr_alloc_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [ptr_alloc_pkg::fifo_ptr_w:0]   count;
    logic                                 do_push;
    logic                                 do_pop;

    // Overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (local_srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_id;
        end
    end

    assign head_id = entries[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == (ptr_alloc_pkg::fifo_ptr_w + 1)'(ptr_alloc_pkg::fifo_depth));

endmodule

// File: hdl/bitmap_ram.sv
// Free bitmap memory
// Fills every row with ones after reset, then serves tagged one-cycle reads
module bitmap_ram (
    input  logic                    clk,
    input  logic                    local_srst,
    input  ptr_alloc_pkg::mem_rd_t  rd,
    input  ptr_alloc_pkg::mem_wr_t  wr,
    output ptr_alloc_pkg::mem_rsp_t rsp,
    output logic                    init_done
);

    ptr_alloc_pkg::row_vec_t mem [ptr_alloc_pkg::num_rows];
    ptr_alloc_pkg::row_idx_t fill_row;
    ptr_alloc_pkg::row_vec_t rd_data;
    logic                    rd_valid;
    logic                    rd_scan;

    // --------------------------------------------------
    // Fill sequencer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            fill_row  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            fill_row <= fill_row + 1'b1;
            if (fill_row == ptr_alloc_pkg::row_idx_t'(ptr_alloc_pkg::num_rows - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // Fill writes win until init_done, external writes after
    always_ff @(posedge clk) begin
        if (!init_done && !local_srst) begin
            mem[fill_row] <= '1;
        end else if (init_done && wr.valid) begin
            mem[wr.row] <= wr.data;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd.valid && init_done;
        end
    end

    always_ff @(posedge clk) begin
        rd_scan <= rd.scan;
        rd_data <= mem[rd.row];
    end

    assign rsp.valid = rd_valid;
    assign rsp.scan  = rd_scan;
    assign rsp.data  = rd_data;

endmodule

// File: hdl/ptr_alloc_pkg.sv
// Pointer allocator shared definitions
// Pool geometry, ID and row types, bitmap memory buses and FSM states
package ptr_alloc_pkg;

    localparam int num_ids    = 64;
    localparam int num_cols   = 8;
    localparam int num_rows   = num_ids / num_cols;
    localparam int col_w      = $clog2(num_cols);
    localparam int row_w      = $clog2(num_rows);
    localparam int cnt_w      = $clog2(num_ids + 1);
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    typedef logic [num_cols-1:0] row_vec_t;
    typedef logic [col_w-1:0]    col_idx_t;
    typedef logic [row_w-1:0]    row_idx_t;

    // Row in the upper bits, so the value equals row*num_cols+col
    typedef struct packed {
        row_idx_t row;
        col_idx_t col;
    } ptr_id_t;

    typedef struct packed {
        logic     valid;
        logic     scan;
        row_idx_t row;
    } mem_rd_t;

    typedef struct packed {
        logic     valid;
        logic     scan;
        row_vec_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic     valid;
        row_idx_t row;
        row_vec_t data;
    } mem_wr_t;

    typedef enum logic [3:0] {
        ctrl_reset,
        ctrl_idle,
        ctrl_dealloc,
        ctrl_alloc,
        ctrl_rd_req,
        ctrl_rd_wait,
        ctrl_modify,
        ctrl_wr,
        ctrl_done,
        ctrl_error
    } ctrl_state_e;

    typedef enum logic [2:0] {
        scan_reset,
        scan_idle,
        scan_rd_req,
        scan_rd_wait,
        scan_check,
        scan_next,
        scan_hold
    } scan_state_e;

endpackage
